// File: Makefile
# Verilator build, run and lint for the GPIO peripheral

VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps -j 0
LFLAGS    := --lint-only --timing --assert --timescale 1ns/1ps
TOP       := tb_gpio
FILELIST  := all.f
OBJ_DIR   := obj_dir
PASS_MSG  := Done: no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# Pass only when the pass line shows up in the simulation output
run: build
	@out=$$(./$(OBJ_DIR)/V$(TOP)); echo "$$out"; echo "$$out" | grep -Fqx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: all.f
+incdir+.
gpio_pkg.sv
gpio_reg_if.sv
gpio_in_sync.sv
gpio_regs.sv
gpio_pin_ctrl.sv
gpio_top.sv
gpio_chk.sv
tb_gpio.sv

// File: gpio_cfg.svh
// GPIO configuration macros

`ifndef GPIO_CFG_SVH
`define GPIO_CFG_SVH

// Number of GPIO pins
`define GPIO_COUNT 16

// Register bus data width
`define GPIO_DATA_WIDTH 32

// Byte address width, 16 word slots
`define GPIO_ADDR_WIDTH 6

// One enable per data byte
`define GPIO_BE_WIDTH 4

// Input synchronizer depth
`define GPIO_SYNC_STAGES 2

// Read data for unmapped words
`define GPIO_BAD_RDATA 32'hBADCAB1E

`endif

// File: gpio_chk.sv
// GPIO protocol assertions

`include "gpio_cfg.svh"

module gpio_chk (
  input logic                   clk_i,
  input logic                   reset_i,
  input logic                   req_i,
  // Response and pad enables of the DUT
  input logic                   rvalid_i,
  input logic                   err_i,
  input logic [`GPIO_COUNT-1:0] gpio_oe_i
);

  timeunit 1ns;
  timeprecision 1ps;

  //////////////////////////////////////////
  // Bus response
  //////////////////////////////////////////

  // Exactly one response, one cycle after each request
  a_rvalid_follows_req: assert property (
    @(posedge clk_i) disable iff (reset_i) rvalid_i == $past(req_i)
  ) else $error("Response valid does not follow the request by one cycle");

  // Error only ever comes with a response
  a_err_needs_rvalid: assert property (
    @(posedge clk_i) disable iff (reset_i) err_i |-> rvalid_i
  ) else $error("Error flag raised without a response");

  //////////////////////////////////////////
  // Pads
  //////////////////////////////////////////

  // Sync reset clears the enables at the reset edge
  a_oe_low_in_reset: assert property (
    @(posedge clk_i) reset_i |=> gpio_oe_i == '0
  ) else $error("Output enables driven while in reset");

endmodule

// File: gpio_golden.txt
# W addr be wdata err | R addr be rdata err | P pins | I cycles | O gpio_o gpio_oe | Q irq
# All fields hex, addr is a byte address
# Reset state
R 00 f 00000000 0
R 04 f 00000000 0
R 08 f 00000000 0
R 0c f 00000000 0
R 10 f 00000000 0
R 14 f 00000000 0
R 18 f 00000000 0
R 1c f 00000000 0
O 0000 0000
Q 0
# Byte-masked writes to DIR, EN and OUT
W 00 1 0000a5f0 0
W 00 2 00003c00 0
R 00 f 00003cf0 0
W 04 3 0000ff0f 0
W 0c 1 12345678 0
W 0c 2 0000ab00 0
R 0c f 0000ab78 0
I 1
O ab08 3c00
# Toggle flips OUT one cycle later
W 10 3 0000ff00 0
I 2
O 5408 3c00
R 10 f 00000000 0
# Input path
P 00a5
I 5
R 08 f 000000a5 0
# Edge interrupt on pin 0, partial then full clear
P 0000
W 1c f 00000001 0
W 14 f 00000003 0
P 0001
I 5
Q 1
R 18 2 00000001 0
Q 1
R 18 1 00000001 0
Q 0
P 0000
I 5
R 18 f 00000000 0
# Level interrupt on pin 1
P 0002
I 5
Q 1
R 18 f 00000002 0
R 18 f 00000002 0
P 0000
I 5
R 18 f 00000002 0
R 18 f 00000000 0
Q 0
# Bad accesses
R 20 f badcab1e 1
W 08 f 0000ffff 1
W 18 f 0000ffff 1
W 24 f 0000ffff 1
R 00 f 00003cf0 0
R 0c f 00005478 0
R 18 f 00000000 0

// File: gpio_in_sync.sv
// GPIO input synchronizer and edge detect

`include "gpio_cfg.svh"

module gpio_in_sync (
  input  logic                   clk_i,
  input  logic                   reset_i,
  // Raw asynchronous pins
  input  logic [`GPIO_COUNT-1:0] gpio_i,
  // Synchronized level
  output logic [`GPIO_COUNT-1:0] sync_o,
  // 0 to 1 transition of the synchronized level
  output logic [`GPIO_COUNT-1:0] rise_o
);

  // Stage 0 samples the pins, last stage is the clean level
  logic [`GPIO_SYNC_STAGES-1:0][`GPIO_COUNT-1:0] sync_q;
  // Previous clean level
  logic [`GPIO_COUNT-1:0]                        prev_q;

  //////////////////////////////////////////
  // Synchronizer chain
  //////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      sync_q <= '0;
      prev_q <= '0;
    end else begin
      sync_q[0] <= gpio_i;
      // Shift one stage per edge
      for (int s = 1; s < `GPIO_SYNC_STAGES; s++) begin
        sync_q[s] <= sync_q[s-1];
      end
      prev_q <= sync_o;
    end
  end

  //////////////////////////////////////////
  // Edge detect
  //////////////////////////////////////////

  assign sync_o = sync_q[`GPIO_SYNC_STAGES-1];

  // High now, low one cycle ago
  assign rise_o = sync_o & ~prev_q;

endmodule

// File: gpio_pin_ctrl.sv
// GPIO pin drive and interrupt logic

`include "gpio_cfg.svh"

module gpio_pin_ctrl (
  input  logic                   clk_i,
  input  logic                   reset_i,
  // From the input synchronizer
  input  logic [`GPIO_COUNT-1:0] sync_i,
  input  logic [`GPIO_COUNT-1:0] rise_i,
  // Register levels and hardware updates
  gpio_reg_if.ctrl               reg_if,
  // Pad side
  output logic [`GPIO_COUNT-1:0] gpio_o,
  output logic [`GPIO_COUNT-1:0] gpio_oe_o,
  output logic                   irq_o
);

  // Per-pin interrupt condition before the enable
  logic [`GPIO_COUNT-1:0] intrpt_cond;
  logic                   irq_q;

  //////////////////////////////////////////
  // Toggle
  //////////////////////////////////////////

  // Flip selected OUT bits, load only when a toggle is pending
  assign reg_if.out_next  = reg_if.out ^ reg_if.toggle;
  assign reg_if.out_valid = |reg_if.toggle;

  // Clean level straight into IN
  assign reg_if.sync_in = sync_i;

  //////////////////////////////////////////
  // Interrupt condition
  //////////////////////////////////////////

  always_comb begin
    for (int p = 0; p < `GPIO_COUNT; p++) begin
      // Edge bit set selects rising edge, else level high
      intrpt_cond[p] = reg_if.intrpt_edge[p] ? rise_i[p] : sync_i[p];
    end
  end

  // Only enabled pins become pending
  assign reg_if.intrpt_set = intrpt_cond & reg_if.intrpt_en;

  // Any pending pin raises the line
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      irq_q <= 1'b0;
    end else begin
      irq_q <= |reg_if.intrpt_status;
    end
  end

  assign irq_o = irq_q;

  //////////////////////////////////////////
  // Pin drive
  //////////////////////////////////////////

  // Disabled pins drive low and float
  assign gpio_o    = reg_if.out & reg_if.en;
  assign gpio_oe_o = reg_if.dir & reg_if.en;

endmodule

// File: gpio_pkg.sv
// GPIO register map

package gpio_pkg;

  //////////////////////////////////////////
  // Register word offsets
  //////////////////////////////////////////

  // Offsets 8 to 15 are unmapped
  typedef enum logic [3:0] {
    // Output direction
    GPIO_DIR           = 4'd0,
    // Pin enable
    GPIO_EN            = 4'd1,
    // Synchronized input, read only
    GPIO_IN            = 4'd2,
    // Output value
    GPIO_OUT           = 4'd3,
    // Write-only flip mask, reads zero
    GPIO_TOGGLE        = 4'd4,
    // Per-pin interrupt enable
    GPIO_INTRPT_EN     = 4'd5,
    // Pending interrupts, clear on read
    GPIO_INTRPT_STATUS = 4'd6,
    // 1 rising edge, 0 level high
    GPIO_INTRPT_EDGE   = 4'd7
  } gpio_reg_addr_e;

endpackage

// File: gpio_reg_if.sv
// Register file to pin control link

`include "gpio_cfg.svh"

interface gpio_reg_if;

  // Register levels seen by the pin logic
  logic [`GPIO_COUNT-1:0] dir;
  logic [`GPIO_COUNT-1:0] en;
  logic [`GPIO_COUNT-1:0] out;
  logic [`GPIO_COUNT-1:0] intrpt_en;
  logic [`GPIO_COUNT-1:0] intrpt_edge;
  logic [`GPIO_COUNT-1:0] intrpt_status;
  // One-cycle pulse of the masked toggle write
  logic [`GPIO_COUNT-1:0] toggle;

  // Hardware updates back into the registers
  logic [`GPIO_COUNT-1:0] sync_in;
  logic [`GPIO_COUNT-1:0] out_next;
  logic                   out_valid;
  // Newly pending interrupts, strobe
  logic [`GPIO_COUNT-1:0] intrpt_set;

  // Register file side
  modport regs (
    output dir, en, out, intrpt_en, intrpt_edge, intrpt_status, toggle,
    input  sync_in, out_next, out_valid, intrpt_set
  );

  // Pin control side
  modport ctrl (
    input  dir, en, out, intrpt_en, intrpt_edge, intrpt_status, toggle,
    output sync_in, out_next, out_valid, intrpt_set
  );

endinterface

// File: gpio_regs.sv
// GPIO register file and bus response

`include "gpio_cfg.svh"

module gpio_regs import gpio_pkg::*; (
  input  logic                        clk_i,
  input  logic                        reset_i,
  // Request, single cycle
  input  logic                        req_i,
  input  logic                        we_i,
  input  logic [`GPIO_ADDR_WIDTH-1:0] addr_i,
  input  logic [`GPIO_BE_WIDTH-1:0]   be_i,
  input  logic [`GPIO_DATA_WIDTH-1:0] wdata_i,
  // Response, one cycle after the request
  output logic                        rvalid_o,
  output logic [`GPIO_DATA_WIDTH-1:0] rdata_o,
  output logic                        err_o,
  // To and from pin control
  gpio_reg_if.regs                    reg_if
);

  // Word offset, byte bits dropped
  logic [3:0]                  word_addr;
  logic                        wr_req;
  logic                        rd_req;
  // One bit per pin, taken from its byte enable
  logic [`GPIO_COUNT-1:0]      bit_mask;
  logic [`GPIO_COUNT-1:0]      wdata;

  // Stored registers
  logic [`GPIO_COUNT-1:0] dir_q, dir_d;
  logic [`GPIO_COUNT-1:0] en_q, en_d;
  logic [`GPIO_COUNT-1:0] in_q, in_d;
  logic [`GPIO_COUNT-1:0] out_q, out_d;
  logic [`GPIO_COUNT-1:0] toggle_q, toggle_d;
  logic [`GPIO_COUNT-1:0] intrpt_en_q, intrpt_en_d;
  logic [`GPIO_COUNT-1:0] intrpt_status_q, intrpt_status_d;
  logic [`GPIO_COUNT-1:0] intrpt_edge_q, intrpt_edge_d;

  // Response stage
  logic                        rvalid_q;
  logic                        err_q, err_d;
  logic [`GPIO_DATA_WIDTH-1:0] rdata_q, rdata_d;

  // Masked bits from the bus, others kept
  function automatic logic [`GPIO_COUNT-1:0] merge(
    input logic [`GPIO_COUNT-1:0] old_val,
    input logic [`GPIO_COUNT-1:0] new_val,
    input logic [`GPIO_COUNT-1:0] mask
  );
    return (old_val & ~mask) | (new_val & mask);
  endfunction

  //////////////////////////////////////////
  // Request decode
  //////////////////////////////////////////

  assign word_addr = addr_i[`GPIO_ADDR_WIDTH-1:2];
  assign wr_req    = req_i & we_i;
  assign rd_req    = req_i & ~we_i;
  assign wdata     = wdata_i[`GPIO_COUNT-1:0];

  for (genvar i = 0; i < `GPIO_COUNT; i++) begin : gen_bit_mask
    assign bit_mask[i] = be_i[i/8];
  end

  //////////////////////////////////////////
  // Next register state
  //////////////////////////////////////////

  always_comb begin
    dir_d         = dir_q;
    en_d          = en_q;
    intrpt_en_d   = intrpt_en_q;
    intrpt_edge_d = intrpt_edge_q;
    // IN follows the synchronized pins every cycle
    in_d          = reg_if.sync_in;
    // Hardware load of OUT after a toggle
    out_d         = reg_if.out_valid ? reg_if.out_next : out_q;
    // Toggle lasts one cycle only
    toggle_d      = '0;
    // New interrupts accumulate
    intrpt_status_d = intrpt_status_q | reg_if.intrpt_set;
    rdata_d       = '0;
    err_d         = 1'b0;

    if (wr_req) begin
      case (word_addr)
        GPIO_DIR:         dir_d = merge(dir_q, wdata, bit_mask);
        GPIO_EN:          en_d = merge(en_q, wdata, bit_mask);
        // Bus write wins over the hardware load
        GPIO_OUT:         out_d = merge(out_d, wdata, bit_mask);
        GPIO_TOGGLE:      toggle_d = wdata & bit_mask;
        GPIO_INTRPT_EN:   intrpt_en_d = merge(intrpt_en_q, wdata, bit_mask);
        GPIO_INTRPT_EDGE: intrpt_edge_d = merge(intrpt_edge_q, wdata, bit_mask);
        // IN, INTRPT_STATUS and unmapped words
        default:          err_d = 1'b1;
      endcase
    end

    if (rd_req) begin
      case (word_addr)
        GPIO_DIR:         rdata_d = `GPIO_DATA_WIDTH'(dir_q);
        GPIO_EN:          rdata_d = `GPIO_DATA_WIDTH'(en_q);
        GPIO_IN:          rdata_d = `GPIO_DATA_WIDTH'(in_q);
        GPIO_OUT:         rdata_d = `GPIO_DATA_WIDTH'(out_q);
        GPIO_TOGGLE:      rdata_d = '0;
        GPIO_INTRPT_EN:   rdata_d = `GPIO_DATA_WIDTH'(intrpt_en_q);
        GPIO_INTRPT_STATUS: begin
          rdata_d = `GPIO_DATA_WIDTH'(intrpt_status_q);
          // Clear what was read, keep this cycle's new interrupts
          intrpt_status_d = (intrpt_status_q & ~bit_mask) | reg_if.intrpt_set;
        end
        GPIO_INTRPT_EDGE: rdata_d = `GPIO_DATA_WIDTH'(intrpt_edge_q);
        default: begin
          rdata_d = `GPIO_BAD_RDATA;
          err_d   = 1'b1;
        end
      endcase
    end
  end

  //////////////////////////////////////////
  // Register update
  //////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      dir_q           <= '0;
      en_q            <= '0;
      in_q            <= '0;
      out_q           <= '0;
      toggle_q        <= '0;
      intrpt_en_q     <= '0;
      intrpt_status_q <= '0;
      intrpt_edge_q   <= '0;
      rvalid_q        <= 1'b0;
      err_q           <= 1'b0;
    end else begin
      dir_q           <= dir_d;
      en_q            <= en_d;
      in_q            <= in_d;
      out_q           <= out_d;
      toggle_q        <= toggle_d;
      intrpt_en_q     <= intrpt_en_d;
      intrpt_status_q <= intrpt_status_d;
      intrpt_edge_q   <= intrpt_edge_d;
      // Every request gets a response
      rvalid_q        <= req_i;
      err_q           <= err_d;
    end
  end

  // Read data, zero for writes
  always_ff @(posedge clk_i) begin
    rdata_q <= rdata_d;
  end

  assign rvalid_o = rvalid_q;
  assign rdata_o  = rdata_q;
  assign err_o    = err_q;

  // Register levels out to pin control
  assign reg_if.dir           = dir_q;
  assign reg_if.en            = en_q;
  assign reg_if.out           = out_q;
  assign reg_if.toggle        = toggle_q;
  assign reg_if.intrpt_en     = intrpt_en_q;
  assign reg_if.intrpt_status = intrpt_status_q;
  assign reg_if.intrpt_edge   = intrpt_edge_q;

endmodule

// File: gpio_top.sv
// GPIO peripheral top level

`include "gpio_cfg.svh"

module gpio_top (
  input  logic                        clk_i,
  input  logic                        reset_i,
  // Register bus request
  input  logic                        req_i,
  input  logic                        we_i,
  input  logic [`GPIO_ADDR_WIDTH-1:0] addr_i,
  input  logic [`GPIO_BE_WIDTH-1:0]   be_i,
  input  logic [`GPIO_DATA_WIDTH-1:0] wdata_i,
  // Register bus response
  output logic                        rvalid_o,
  output logic [`GPIO_DATA_WIDTH-1:0] rdata_o,
  output logic                        err_o,
  // Pins
  input  logic [`GPIO_COUNT-1:0]      gpio_i,
  output logic [`GPIO_COUNT-1:0]      gpio_o,
  output logic [`GPIO_COUNT-1:0]      gpio_oe_o,
  // Interrupt line
  output logic                        irq_o
);

  // Synchronized level and rising edges
  logic [`GPIO_COUNT-1:0] sync_in;
  logic [`GPIO_COUNT-1:0] rise;

  gpio_reg_if reg_if ();

  // Input side
  gpio_in_sync u_in_sync (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .gpio_i  (gpio_i),
    .sync_o  (sync_in),
    .rise_o  (rise)
  );

  // Register file
  gpio_regs u_regs (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .req_i    (req_i),
    .we_i     (we_i),
    .addr_i   (addr_i),
    .be_i     (be_i),
    .wdata_i  (wdata_i),
    .rvalid_o (rvalid_o),
    .rdata_o  (rdata_o),
    .err_o    (err_o),
    .reg_if   (reg_if.regs)
  );

  // Output side
  gpio_pin_ctrl u_pin_ctrl (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .sync_i    (sync_in),
    .rise_i    (rise),
    .reg_if    (reg_if.ctrl),
    .gpio_o    (gpio_o),
    .gpio_oe_o (gpio_oe_o),
    .irq_o     (irq_o)
  );

endmodule

// File: tb_gpio.sv
// GPIO testbench driven by the golden file

`include "gpio_cfg.svh"

module tb_gpio import gpio_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  // Wait limits in cycles
  localparam int RESP_TIMEOUT = 8;
  localparam int IRQ_TIMEOUT  = 20;

  logic                        clk_i;
  logic                        reset_i;
  logic                        req_i;
  logic                        we_i;
  logic [`GPIO_ADDR_WIDTH-1:0] addr_i;
  logic [`GPIO_BE_WIDTH-1:0]   be_i;
  logic [`GPIO_DATA_WIDTH-1:0] wdata_i;
  logic                        rvalid_o;
  logic [`GPIO_DATA_WIDTH-1:0] rdata_o;
  logic                        err_o;
  logic [`GPIO_COUNT-1:0]      gpio_i;
  logic [`GPIO_COUNT-1:0]      gpio_o;
  logic [`GPIO_COUNT-1:0]      gpio_oe_o;
  logic                        irq_o;

  int fd;
  int mismatch_count;
  int fail_count;

  gpio_top uut (.*);

  bind gpio_top gpio_chk u_chk (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .req_i     (req_i),
    .rvalid_i  (rvalid_o),
    .err_i     (err_o),
    .gpio_oe_i (gpio_oe_o)
  );

  // 100 ns clock
  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      mismatch_count++;
      $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  // Ends 10 ns after the last edge, where inputs are driven
  task automatic step_cycles(input int n);
    repeat (n) begin
      @(posedge clk_i);
      #10;
    end
  endtask

  function automatic string reg_label(input logic [31:0] addr);
    gpio_reg_addr_e word;
    if (addr[`GPIO_ADDR_WIDTH-1]) begin
      return "rdata_o at unmapped word";
    end
    word = gpio_reg_addr_e'(addr[`GPIO_ADDR_WIDTH-1:2]);
    return {"rdata_o at ", word.name()};
  endfunction

  // One request, then wait for its response
  task automatic bus_access(input logic we, input logic [31:0] addr, input logic [31:0] be,
                            input logic [31:0] wdata, input logic [31:0] exp_rdata,
                            input logic exp_err);
    int wait_cycles;
    req_i   = 1'b1;
    we_i    = we;
    addr_i  = addr[`GPIO_ADDR_WIDTH-1:0];
    be_i    = be[`GPIO_BE_WIDTH-1:0];
    wdata_i = wdata;
    step_cycles(1);
    req_i   = 1'b0;
    we_i    = 1'b0;
    wait_cycles = 0;
    while (!rvalid_o && wait_cycles < RESP_TIMEOUT) begin
      step_cycles(1);
      wait_cycles++;
    end
    if (!rvalid_o) begin
      fail_count++;
      $display("No bus response for the access at address 0x%h", addr);
    end else begin
      check_value(reg_label(addr), rdata_o, exp_rdata);
      check_value("err_o", 32'(err_o), 32'(exp_err));
    end
  endtask

  task automatic wait_irq(input logic exp);
    int cycles;
    cycles = 0;
    while (irq_o !== exp && cycles < IRQ_TIMEOUT) begin
      step_cycles(1);
      cycles++;
    end
    if (irq_o !== exp) begin
      fail_count++;
      $display("Interrupt line did not reach %0b within %0d cycles", exp, IRQ_TIMEOUT);
    end
  endtask

  // Next command letter, skipping blanks and comment lines
  // Codes: 32 space, 9 tab, 10 newline, 13 return, 35 hash
  function automatic int read_cmd_char();
    int c;
    c = $fgetc(fd);
    while (c == 32 || c == 9 || c == 10 || c == 13 || c == 35) begin
      if (c == 35) begin
        while (c != 10 && c != -1) begin
          c = $fgetc(fd);
        end
      end
      c = $fgetc(fd);
    end
    return c;
  endfunction

  ////////////////////////////////////////
  // Golden file sequencer
  ////////////////////////////////////////

  task automatic run_golden();
    int          cmd;
    int          n;
    int          need;
    logic [31:0] f0, f1, f2, f3;
    cmd = read_cmd_char();
    while (cmd != -1) begin
      n    = 0;
      need = 1;
      case (8'(cmd))
        "W": begin
          need = 4;
          n = $fscanf(fd, "%h %h %h %h", f0, f1, f2, f3);
          if (n == need) bus_access(1'b1, f0, f1, f2, 32'h0, f3[0]);
        end
        "R": begin
          need = 4;
          n = $fscanf(fd, "%h %h %h %h", f0, f1, f2, f3);
          if (n == need) bus_access(1'b0, f0, f1, 32'h0, f2, f3[0]);
        end
        "P": begin
          n = $fscanf(fd, "%h", f0);
          gpio_i = f0[`GPIO_COUNT-1:0];
        end
        "I": begin
          n = $fscanf(fd, "%h", f0);
          if (n == need) step_cycles(int'(f0));
        end
        "O": begin
          need = 2;
          n = $fscanf(fd, "%h %h", f0, f1);
          check_value("gpio_o", 32'(gpio_o), f0);
          check_value("gpio_oe_o", 32'(gpio_oe_o), f1);
        end
        "Q": begin
          n = $fscanf(fd, "%h", f0);
          if (n == need) wait_irq(f0[0]);
        end
        default: n = 0;
      endcase
      if (n != need) begin
        fail_count++;
        $display("Golden command %c is unknown or has missing fields", 8'(cmd));
        cmd = -1;
      end else begin
        cmd = read_cmd_char();
      end
    end
  endtask

  task automatic finish_run();
    $display("Errors: %0d value mismatches, %0d other failures", mismatch_count, fail_count);
    if (mismatch_count == 0 && fail_count == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  endtask

  initial begin
    reset_i        = 1'b1;
    req_i          = 1'b0;
    we_i           = 1'b0;
    addr_i         = '0;
    be_i           = '0;
    wdata_i        = '0;
    gpio_i         = '0;
    mismatch_count = 0;
    fail_count     = 0;
    // Two reset cycles
    repeat (2) @(posedge clk_i);
    #10;
    reset_i = 1'b0;
    fd = $fopen("gpio_golden.txt", "r");
    if (fd == 0) begin
      fail_count++;
      $display("Could not open the golden file gpio_golden.txt");
    end else begin
      run_golden();
      $fclose(fd);
    end
    finish_run();
  end

endmodule
